// File: hdl/rv_alu_cfg.svh
`ifndef RV_ALU_CFG_SVH
`define RV_ALU_CFG_SVH

// Datapath and instruction word width
`define RV_XLEN 32

// Register file addressing
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// Decoded operations buffered between decode and execute
`define RV_QUEUE_DEPTH 4

`endif

// File: hdl/rv_alu_pkg.sv
`default_nettype none

`include "rv_alu_cfg.svh"

package rv_alu_pkg;

    // Data and instruction words
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Shift amount, low bits of operand b
    typedef logic [4:0] shamt_t;

    // ALU operations, PASS_B serves LUI
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Major opcodes kept from RV32I
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

// File: hdl/dec_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_op_if;
    import rv_alu_pkg::*;

    logic      valid;
    alu_op_e   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
    logic      use_imm;
    logic      rd_wren;
    logic      insn_vld;

    modport src (
        output valid, alu_op, rd, rs1, rs2, imm, use_imm, rd_wren, insn_vld
    );

    modport dst (
        input valid, alu_op, rd, rs1, rs2, imm, use_imm, rd_wren, insn_vld
    );

endinterface

`default_nettype wire

// File: hdl/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  rv_alu_pkg::word_t wb_dat_i,
    output logic              wb_ack_o,
    input  logic              op_ready_i,
    dec_op_if.src             op
);
    import rv_alu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    logic       legal;

    assign opcode = wb_dat_i[6:0];
    assign funct3 = wb_dat_i[14:12];
    assign funct7 = wb_dat_i[31:25];
    assign imm_i  = {{20{wb_dat_i[31]}}, wb_dat_i[31:20]};
    assign imm_u  = {wb_dat_i[31:12], 12'b0};

    // A request is pending until acked; push lands on the accepting edge
    assign op.valid = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_comb begin
        legal      = 1'b0;
        op.use_imm = 1'b0;
        op.imm     = imm_i;
        // Shared funct3 mapping for register and immediate forms
        case (funct3)
            3'b000:  op.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  op.alu_op = ALU_SLL;
            3'b010:  op.alu_op = ALU_SLT;
            3'b011:  op.alu_op = ALU_SLTU;
            3'b100:  op.alu_op = ALU_XOR;
            3'b101:  op.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  op.alu_op = ALU_OR;
            default: op.alu_op = ALU_AND;
        endcase
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                op.use_imm = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                legal      = 1'b1;
                op.use_imm = 1'b1;
                op.imm     = imm_u;
                op.alu_op  = ALU_PASS_B;
            end
            default: legal = 1'b0;
        endcase
    end

    assign op.rs1      = wb_dat_i[19:15];
    assign op.rs2      = wb_dat_i[24:20];
    // Illegal words retire as no-ops targeting x0
    assign op.rd       = legal ? wb_dat_i[11:7] : '0;
    assign op.rd_wren  = legal;
    assign op.insn_vld = legal;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= op.valid & op_ready_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/op_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_cfg.svh"

module op_queue #(
    parameter int unsigned DEPTH = `RV_QUEUE_DEPTH
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    dec_op_if.dst push,
    output logic  push_ready_o,
    dec_op_if.src head,
    input  logic  pop_i
);
    import rv_alu_pkg::*;

    localparam int unsigned AW = $clog2(DEPTH);

    // Entry storage, one array per field
    alu_op_e   op_mem   [DEPTH];
    reg_addr_t rd_mem   [DEPTH];
    reg_addr_t rs1_mem  [DEPTH];
    reg_addr_t rs2_mem  [DEPTH];
    word_t     imm_mem  [DEPTH];
    logic      uimm_mem [DEPTH];
    logic      wren_mem [DEPTH];
    logic      vld_mem  [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign push_ready_o = (count != (AW+1)'(DEPTH));
    assign head.valid   = (count != '0);
    assign do_push      = push.valid & push_ready_o;
    assign do_pop       = pop_i & head.valid;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            op_mem[wr_ptr]   <= push.alu_op;
            rd_mem[wr_ptr]   <= push.rd;
            rs1_mem[wr_ptr]  <= push.rs1;
            rs2_mem[wr_ptr]  <= push.rs2;
            imm_mem[wr_ptr]  <= push.imm;
            uimm_mem[wr_ptr] <= push.use_imm;
            wren_mem[wr_ptr] <= push.rd_wren;
            vld_mem[wr_ptr]  <= push.insn_vld;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head.alu_op   = op_mem[rd_ptr];
    assign head.rd       = rd_mem[rd_ptr];
    assign head.rs1      = rs1_mem[rd_ptr];
    assign head.rs2      = rs2_mem[rd_ptr];
    assign head.imm      = imm_mem[rd_ptr];
    assign head.use_imm  = uimm_mem[rd_ptr];
    assign head.rd_wren  = wren_mem[rd_ptr];
    assign head.insn_vld = vld_mem[rd_ptr];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_alu_pkg::word_t   a_i,
    input  rv_alu_pkg::word_t   b_i,
    input  rv_alu_pkg::alu_op_e op_i,
    output rv_alu_pkg::word_t   y_o
);
    import rv_alu_pkg::*;

    shamt_t shamt;

    // Only the low five bits count for shifts
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:    y_o = a_i + b_i;
            ALU_SUB:    y_o = a_i - b_i;
            ALU_SLL:    y_o = a_i << shamt;
            ALU_SLT:    y_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU:   y_o = word_t'(a_i < b_i);
            ALU_XOR:    y_o = a_i ^ b_i;
            ALU_SRL:    y_o = a_i >> shamt;
            ALU_SRA:    y_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:     y_o = a_i | b_i;
            ALU_AND:    y_o = a_i & b_i;
            // LUI, immediate already shifted up
            ALU_PASS_B: y_o = b_i;
            default:    y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_cfg.svh"

module exec_unit (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    dec_op_if.dst                 op,
    output logic                  op_take_o,
    input  logic                  retire_rdy_i,
    output logic                  retire_vld_o,
    output logic                  retire_insn_vld_o,
    output rv_alu_pkg::reg_addr_t retire_rd_o,
    output rv_alu_pkg::word_t     retire_data_o
);
    import rv_alu_pkg::*;

    word_t     rf [`RV_NUM_REGS];

    // Result register, the single in-flight instruction
    logic      res_vld;
    logic      res_insn_vld;
    logic      res_rd_wren;
    reg_addr_t res_rd;
    word_t     res_data;

    logic      retire_fire;
    logic      fwd_ok;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     opb;
    word_t     alu_y;

    assign retire_fire = res_vld & retire_rdy_i;
    // Take the head when the result slot is free or emptying this cycle
    assign op_take_o   = op.valid & (~res_vld | retire_fire);

    // Register file write happens on retirement
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (retire_fire && res_rd_wren && res_rd != '0) begin
            rf[res_rd] <= res_data;
        end
    end

    // Bypass from the result register, x0 never forwarded
    assign fwd_ok  = res_vld & res_rd_wren & (res_rd != '0);
    assign rs1_val = (op.rs1 == '0)                 ? '0       :
                     (fwd_ok && res_rd == op.rs1)   ? res_data : rf[op.rs1];
    assign rs2_val = (op.rs2 == '0)                 ? '0       :
                     (fwd_ok && res_rd == op.rs2)   ? res_data : rf[op.rs2];

    assign opb = op.use_imm ? op.imm : rs2_val;

    alu u_alu (
        .a_i  (rs1_val),
        .b_i  (opb),
        .op_i (op.alu_op),
        .y_o  (alu_y)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_vld      <= 1'b0;
            res_insn_vld <= 1'b0;
            res_rd_wren  <= 1'b0;
            res_rd       <= '0;
            res_data     <= '0;
        end else if (op_take_o) begin
            res_vld      <= 1'b1;
            res_insn_vld <= op.insn_vld;
            res_rd_wren  <= op.rd_wren;
            res_rd       <= op.rd;
            // Illegal instructions retire with zero data
            res_data     <= op.insn_vld ? alu_y : '0;
        end else if (retire_fire) begin
            res_vld <= 1'b0;
        end
    end

    assign retire_vld_o      = res_vld;
    assign retire_insn_vld_o = res_insn_vld;
    assign retire_rd_o       = res_rd;
    assign retire_data_o     = res_data;

endmodule

`default_nettype wire

// File: hdl/rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_cfg.svh"

module rv_alu_core (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Wishbone classic instruction slave
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  rv_alu_pkg::word_t     wb_dat_i,
    output logic                  wb_ack_o,
    // Retire trace port
    input  logic                  retire_rdy_i,
    output logic                  retire_vld_o,
    output logic                  retire_insn_vld_o,
    output rv_alu_pkg::reg_addr_t retire_rd_o,
    output rv_alu_pkg::word_t     retire_data_o
);

    logic op_ready;
    logic op_take;

    dec_op_if dec_op ();
    dec_op_if head_op ();

    insn_decoder u_insn_decoder (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .op_ready_i (op_ready),
        .op         (dec_op.src)
    );

    op_queue #(
        .DEPTH (`RV_QUEUE_DEPTH)
    ) u_op_queue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push         (dec_op.dst),
        .push_ready_o (op_ready),
        .head         (head_op.src),
        .pop_i        (op_take)
    );

    exec_unit u_exec_unit (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .op                (head_op.dst),
        .op_take_o         (op_take),
        .retire_rdy_i      (retire_rdy_i),
        .retire_vld_o      (retire_vld_o),
        .retire_insn_vld_o (retire_insn_vld_o),
        .retire_rd_o       (retire_rd_o),
        .retire_data_o     (retire_data_o)
    );

endmodule

`default_nettype wire

// File: testbench/rv_alu_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_core_checker (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  wb_cyc_i,
    input logic                  wb_stb_i,
    input logic                  wb_ack_o,
    input logic                  retire_rdy_i,
    input logic                  retire_vld_o,
    input logic                  retire_insn_vld_o,
    input rv_alu_pkg::reg_addr_t retire_rd_o,
    input rv_alu_pkg::word_t     retire_data_o
);

    // Ack only answers a live strobe
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o high without cyc and stb");

    // Single-cycle ack pulse
    ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o high for two cycles in a row");

    // Stalled retirement holds its payload
    retire_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (retire_vld_o && !retire_rdy_i) |=>
            (retire_vld_o && $stable(retire_insn_vld_o) &&
             $stable(retire_rd_o) && $stable(retire_data_o)))
        else $error("retire port changed while stalled");

    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !retire_vld_o)
        else $error("retire_vld_o high during reset");

endmodule

bind rv_alu_core rv_alu_core_checker u_checker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_ack_o          (wb_ack_o),
    .retire_rdy_i      (retire_rdy_i),
    .retire_vld_o      (retire_vld_o),
    .retire_insn_vld_o (retire_insn_vld_o),
    .retire_rd_o       (retire_rd_o),
    .retire_data_o     (retire_data_o)
);

`default_nettype wire

// File: testbench/tb_rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_cfg.svh"

module tb_rv_alu_core;

    localparam int N_RAND    = 2000;
    localparam int N_CHAIN   = 300;
    localparam int N_STALL   = 300;
    localparam int N_ILLEGAL = 300;
    localparam int N_ZERO    = 20;
    localparam int N_TOTAL   = 1 + N_RAND + N_CHAIN + N_STALL + 2 * N_ILLEGAL + 2 * N_ZERO;
    // Worst case per instruction with long retire stalls
    localparam int CYCLES_PER_INSN = 64;

    logic        clk_i;
    logic        rst_ni;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic [31:0] wb_dat_i;
    logic        wb_ack_o;
    logic        retire_rdy_i = 1'b0;
    logic        retire_vld_o;
    logic        retire_insn_vld_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    logic [31:0] seed = 32'hb55b_918f;
    logic [31:0] model_rf [32];
    logic        exp_vld [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          hold_cnt = 0;
    logic        stall_mode = 1'b0;

    rv_alu_core UUT (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_dat_i          (wb_dat_i),
        .wb_ack_o          (wb_ack_o),
        .retire_rdy_i      (retire_rdy_i),
        .retire_vld_o      (retire_vld_o),
        .retire_insn_vld_o (retire_insn_vld_o),
        .retire_rd_o       (retire_rd_o),
        .retire_data_o     (retire_data_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rnd_reg();
        logic [31:0] r;
        r = rnd();
        return r[4:0];
    endfunction

    // RV32I result for a funct3, alt picks SUB or SRA
    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs one word on the model and queues its expected retirement
    function automatic void predict(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic        ok;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        a   = model_rf[w[19:15]];
        ok  = 1'b0;
        y   = 32'h0;
        if (opc == 7'h33) begin
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            y  = isa_alu(f3, f7[5], a, model_rf[w[24:20]]);
        end else if (opc == 7'h13) begin
            b  = {{20{w[31]}}, w[31:20]};
            ok = (f3 == 3'd1) ? (f7 == 7'h00) :
                 (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            y  = isa_alu(f3, (f3 == 3'd5) && f7[5], a, b);
        end else if (opc == 7'h37) begin
            ok = 1'b1;
            y  = {w[31:12], 12'h000};
        end
        if (!ok) begin
            rd = 5'd0;
            y  = 32'h0;
        end
        if (ok && rd != 5'd0) model_rf[rd] = y;
        exp_vld.push_back(ok);
        exp_rd.push_back(rd);
        exp_data.push_back(y);
    endfunction

    function automatic logic [31:0] make_legal(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = rnd();
        f3 = r[2:0];
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[3]) ? 7'h20 : 7'h00;
        case (r[5:4])
            2'd0: return {f7, rs2, rs1, f3, rd, 7'h33};
            2'd3: return {r[31:12], rd, 7'h37};
            default: begin
                if (f3 == 3'd1 || f3 == 3'd5) return {f7, r[24:20], rs1, f3, rd, 7'h13};
                return {r[31:20], rs1, f3, rd, 7'h13};
            end
        endcase
    endfunction

    function automatic logic [31:0] make_illegal();
        logic [31:0] r;
        r = rnd();
        case (r[1:0])
            // M extension encodings
            2'd0: return {7'h01, r[24:7], 7'h33};
            // SLLI with a nonzero funct7
            2'd1: return {7'h20, r[24:15], 3'd1, r[11:7], 7'h13};
            default: begin
                if (r[6:0] == 7'h33 || r[6:0] == 7'h13 || r[6:0] == 7'h37) begin
                    return {r[31:7], r[6:0] ^ 7'h40};
                end
                return r;
            end
        endcase
    endfunction

    // Wishbone classic write, held until the rising edge that sees ack
    task automatic issue(input logic [31:0] w);
        int in_flight;
        predict(w);
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_dat_i = w;
        @(negedge clk_i);
        while (!wb_ack_o) @(negedge clk_i);
        // Outstanding right after the accepting edge, pop for the next edge added back
        #1;
        in_flight = exp_data.size() + ((retire_vld_o && retire_rdy_i) ? 1 : 0);
        assert (in_flight <= `RV_QUEUE_DEPTH + 1) else begin
            other_cnt++;
            $display("Ack given while queue and result register were already full at %0t",
                     $time);
        end
        @(negedge clk_i);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_data.size() != 0) @(negedge clk_i);
    endtask

    // Retire checker and ready generator
    always @(negedge clk_i) begin : retire_monitor
        logic        e_vld;
        logic [4:0]  e_rd;
        logic [31:0] e_data;
        logic [31:0] r;
        // Ready chosen here meets the payload at the next rising edge
        if (!rst_ni) begin
            retire_rdy_i = 1'b0;
            hold_cnt     = 0;
        end else if (hold_cnt != 0) begin
            hold_cnt--;
        end else begin
            r = rnd();
            if (stall_mode) begin
                retire_rdy_i = r[0];
                hold_cnt     = int'(r[8:4]);
            end else begin
                retire_rdy_i = (r[1:0] != 2'b00);
            end
        end
        if (retire_vld_o && retire_rdy_i) begin
            if (exp_data.size() == 0) begin
                other_cnt++;
                $display("Unexpected retirement at %0t with nothing outstanding", $time);
            end else begin
                e_vld  = exp_vld.pop_front();
                e_rd   = exp_rd.pop_front();
                e_data = exp_data.pop_front();
                assert (retire_insn_vld_o == e_vld && retire_rd_o == e_rd &&
                        retire_data_o == e_data) else begin
                    mismatch_cnt++;
                    $display("mismatch at %0t: got vld %0b rd x%0d data %h, want %0b x%0d %h",
                             $time, retire_insn_vld_o, retire_rd_o, retire_data_o,
                             e_vld, e_rd, e_data);
                end
            end
        end
    end

    initial begin
        #(N_TOTAL * CYCLES_PER_INSN * 10);
        $display("Timeout: the run did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [4:0] prev;
        logic [4:0] rd;
        clk_i    = 1'b0;
        rst_ni   = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_dat_i = 32'h0;
        for (int i = 0; i < 32; i++) model_rf[i] = 32'h0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        assert (!wb_ack_o && !retire_vld_o) else begin
            other_cnt++;
            $display("Ack or retire valid high right after reset");
        end
        // ADDI x1, x0, 0x5a5
        issue({12'h5a5, 5'd0, 3'd0, 5'd1, 7'h13});
        drain();
        for (int i = 0; i < N_RAND; i++) issue(make_legal(rnd_reg(), rnd_reg(), rnd_reg()));
        // Dependency chains through forwarding
        prev = 5'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = rnd_reg();
            if (rd == 5'd0) rd = 5'd1;
            issue(make_legal(rd, prev, prev));
            prev = rd;
        end
        stall_mode = 1'b1;
        for (int i = 0; i < N_STALL; i++) issue(make_legal(rnd_reg(), rnd_reg(), rnd_reg()));
        drain();
        stall_mode = 1'b0;
        for (int i = 0; i < N_ILLEGAL; i++) begin
            issue(make_illegal());
            issue(make_legal(rnd_reg(), rnd_reg(), rnd_reg()));
        end
        // Writes to x0 followed by ADD rd, x0, x0
        for (int i = 0; i < N_ZERO; i++) begin
            issue(make_legal(5'd0, rnd_reg(), rnd_reg()));
            issue({7'h00, 5'd0, 5'd0, 3'd0, rnd_reg(), 7'h33});
        end
        drain();
        repeat (20) @(negedge clk_i);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_alu_core.f
+incdir+hdl
hdl/rv_alu_pkg.sv
hdl/dec_op_if.sv
hdl/insn_decoder.sv
hdl/op_queue.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/rv_alu_core.sv
testbench/rv_alu_core_checker.sv
testbench/tb_rv_alu_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_alu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_alu_core.f --top-module tb_rv_alu_core -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
